// ==== lsu.f ====
lsu_pkg.sv
lsu_store_align.sv
lsu_load_extend.sv
lsu_ctrl.sv
axi_sram.sv
lsu_top.sv
tb_lsu_top.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_lsu_top
FILELIST  = lsu.f
LOG       = sim.log
FAIL_MSG  = === FAIL ===
PASS_MSG  = === PASS ===

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q -F -e "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q -F -e "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_lsu_top.sv ====
`timescale 1ns/1ps

module tb_lsu_top
    import lsu_pkg::*;
();

    logic        clk;
    logic        rst;
    logic        req_valid;
    lsu_req_t    req;
    logic        req_ready;
    logic        res_valid;
    lsu_res_t    res;
    logic        res_ready;

    logic [31:0] model [SRAM_WORDS]; // Mirror of the SRAM contents.
    string       row_name [$];
    lsu_req_t    row_req [$];
    lsu_res_t    row_exp [$];
    int          errors;
    int          cycles;
    int          limit;

    lsu_top lsu_top_inst (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ########################################
    // Reference model and stimulus table
    // ########################################

    function automatic int access_bytes(input mem_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            default: return 4;
        endcase
    endfunction

    task automatic add_row(input string name, input mem_op_e op, input logic [31:0] addr,
                           input logic [31:0] wdata);
        lsu_req_t           rq;
        lsu_res_t           ex;
        logic [31:0]        raw;
        logic [SRAM_AW-1:0] idx;
        logic               hit;
        int                 lane;
        rq.op    = op;
        rq.addr  = addr;
        rq.wdata = wdata;
        rq.rd    = 5'(row_req.size() + 1);
        ex.rd    = rq.rd;
        ex.fault = 1'b0;
        ex.rdata = 32'b0;
        raw      = 32'b0;
        hit      = (addr[31:SRAM_AW+2] == SRAM_BASE[31:SRAM_AW+2]); // Window is 1 KiB aligned.
        idx      = addr[SRAM_AW+1:2];
        if (op == OP_NONE) begin
            ex.rdata = addr;
        end else if (!hit) begin
            ex.fault = 1'b1; // Memory stays as it was.
        end else begin
            for (int b = 0; b < access_bytes(op); b++) begin
                lane = int'(addr[1:0]) + b;
                if (op inside {OP_SB, OP_SH, OP_SW}) begin
                    model[idx][lane*8 +: 8] = wdata[b*8 +: 8];
                end else begin
                    raw[b*8 +: 8] = model[idx][lane*8 +: 8];
                end
            end
            case (op)
                OP_LB: ex.rdata = {{24{raw[7]}}, raw[7:0]};
                OP_LH: ex.rdata = {{16{raw[15]}}, raw[15:0]};
                default: ex.rdata = raw; // Zero-extending loads and LW.
            endcase
        end
        row_name.push_back(name);
        row_req.push_back(rq);
        row_exp.push_back(ex);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [31:0] a;
        add_row("sw_word", OP_SW, SRAM_BASE + 32'h10, 32'hdead_beef);
        add_row("lw_word", OP_LW, SRAM_BASE + 32'h10, 32'h0);
        add_row("sw_fill", OP_SW, SRAM_BASE + 32'h20, 32'h8877_6655);
        for (int off = 0; off < 4; off++) begin
            rnd = $urandom();
            rnd[7] = (off % 2 == 0); // Mix negative and positive bytes.
            a = SRAM_BASE + 32'h20 + 32'(off);
            add_row($sformatf("sb_off%0d", off), OP_SB, a, rnd);
            add_row($sformatf("lw_after_sb%0d", off), OP_LW, SRAM_BASE + 32'h20, 32'h0);
            add_row($sformatf("lb_off%0d", off), OP_LB, a, 32'h0);
            add_row($sformatf("lbu_off%0d", off), OP_LBU, a, 32'h0);
        end
        for (int off = 0; off < 4; off += 2) begin
            rnd = $urandom();
            rnd[15] = (off == 0);
            a = SRAM_BASE + 32'h30 + 32'(off);
            add_row($sformatf("sh_off%0d", off), OP_SH, a, rnd);
            add_row($sformatf("lw_after_sh%0d", off), OP_LW, SRAM_BASE + 32'h30, 32'h0);
            add_row($sformatf("lh_off%0d", off), OP_LH, a, 32'h0);
            add_row($sformatf("lhu_off%0d", off), OP_LHU, a, 32'h0);
        end
        add_row("none_pass", OP_NONE, SRAM_BASE + 32'h20, 32'hffff_ffff);
        add_row("lw_after_none", OP_LW, SRAM_BASE + 32'h20, 32'h0);
        // The out of window addresses alias words 0x10 and 0x20 in the index bits.
        add_row("sw_below", OP_SW, 32'h0000_0010, 32'h1234_5678);
        add_row("lw_below", OP_LW, 32'h0000_0010, 32'h0);
        add_row("lb_above", OP_LB, SRAM_BASE + 32'(SRAM_WORDS * 4) + 32'h3, 32'h0);
        add_row("sh_above", OP_SH, SRAM_BASE + 32'(SRAM_WORDS * 4) + 32'h22, 32'hffff);
        add_row("lw_after_oob10", OP_LW, SRAM_BASE + 32'h10, 32'h0);
        add_row("lw_after_oob20", OP_LW, SRAM_BASE + 32'h20, 32'h0);
        for (int k = 0; k < 6; k++) begin
            a = SRAM_BASE + 32'($urandom_range(0, SRAM_WORDS - 1) << 2);
            add_row($sformatf("sw_rand%0d", k), OP_SW, a, $urandom());
            add_row($sformatf("lw_rand%0d", k), OP_LW, a, 32'h0);
        end
    endtask

    // ########################################
    // Checks and row driver
    // ########################################

    task automatic check_res(input string name, input lsu_res_t exp, input lsu_res_t act);
        string exp_s;
        string act_s;
        if (act !== exp) begin
            errors++;
            exp_s = $sformatf("rdata=%08h rd=%0d fault=%0b", exp.rdata, exp.rd, exp.fault);
            act_s = $sformatf("rdata=%08h rd=%0d fault=%0b", act.rdata, act.rd, act.fault);
            $display("ERROR %s: expected %s, actual %s", name, exp_s, act_s);
        end
    endtask

    task automatic check_ready(input string name, input string sig, input logic exp,
                               input logic act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: %s expected %0b, actual %0b", name, sig, exp, act);
        end
    endtask

    task automatic run_row(input int i);
        lsu_res_t held;
        int       stall;
        stall = $urandom_range(0, 4);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= row_req[i];
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk); // Request is taken at this edge.
        req_valid <= 1'b0;
        @(negedge clk);
        while (!res_valid) @(negedge clk);
        check_res(row_name[i], row_exp[i], res);
        held = res;
        repeat (stall) begin
            @(negedge clk);
            check_res(row_name[i], held, res);
            check_ready(row_name[i], "res_valid", 1'b1, res_valid);
            check_ready(row_name[i], "req_ready", 1'b0, req_ready);
        end
        @(posedge clk);
        res_ready <= 1'b1;
        @(negedge clk);
        check_ready(row_name[i], "req_ready", 1'b0, req_ready);
        @(posedge clk);
        res_ready <= 1'b0;
        @(negedge clk);
        check_ready(row_name[i], "req_ready", 1'b1, req_ready); // Back in IDLE after transfer.
    endtask

    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the stage gave no result within %0d cycles", limit);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        void'($urandom(32'h12b4_ebc1));
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        res_ready = 1'b0;
        errors    = 0;
        limit     = 0;
        for (int i = 0; i < SRAM_WORDS; i++) begin
            model[i] = 32'b0; // SRAM resets to zero.
        end
        build_table();
        limit = 40 * row_req.size() + 10;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < row_req.size(); i++) begin
            run_row(i);
        end
        repeat (2) @(posedge clk);
        $display("Summary: %0d rows, %0d errors", row_req.size(), errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top
    import lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    input  lsu_req_t req,
    output logic     req_ready,
    output logic     res_valid,
    output lsu_res_t res,
    input  logic     res_ready
);

    logic        awvalid;
    logic        awready;
    axi_aw_t     aw;
    logic        wvalid;
    logic        wready;
    axi_w_t      w;
    logic        bvalid;
    logic        bready;
    axi_b_t      b;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic        rvalid;
    logic        rready;
    axi_r_t      r;

    lsu_ctrl lsu_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready),
        .awvalid   (awvalid),
        .aw        (aw),
        .awready   (awready),
        .wvalid    (wvalid),
        .w         (w),
        .wready    (wready),
        .bvalid    (bvalid),
        .b         (b),
        .bready    (bready),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .arready   (arready),
        .rvalid    (rvalid),
        .r         (r),
        .rready    (rready)
    );

    axi_sram axi_sram_inst (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .aw      (aw),
        .awready (awready),
        .wvalid  (wvalid),
        .w       (w),
        .wready  (wready),
        .bvalid  (bvalid),
        .b       (b),
        .bready  (bready),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arready (arready),
        .rvalid  (rvalid),
        .r       (r),
        .rready  (rready)
    );

endmodule

// ==== axi_sram.sv ====
`timescale 1ns/1ps

module axi_sram
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        awvalid,
    input  axi_aw_t     aw,
    output logic        awready,
    input  logic        wvalid,
    input  axi_w_t      w,
    output logic        wready,
    output logic        bvalid,
    output axi_b_t      b,
    input  logic        bready,
    input  logic        arvalid,
    input  logic [31:0] araddr,
    output logic        arready,
    output logic        rvalid,
    output axi_r_t      r,
    input  logic        rready
);

    logic [31:0]        mem [SRAM_WORDS];
    logic               idle;
    logic               wr_take;
    logic               rd_take;
    logic               wr_hit;
    logic               rd_hit;
    logic [SRAM_AW-1:0] wr_idx;
    logic [SRAM_AW-1:0] rd_idx;

    function automatic logic in_window(input logic [31:0] addr);
        return (addr >= SRAM_BASE) && (addr - SRAM_BASE < SRAM_WORDS * 4);
    endfunction

    assign idle    = !rvalid && !bvalid;
    assign arready = idle;
    assign rd_take = arvalid && arready;
    assign wr_take = idle && awvalid && wvalid && !arvalid; // Reads win a tie.
    assign awready = wr_take;
    assign wready  = wr_take;

    assign wr_hit = in_window(aw.addr);
    assign rd_hit = in_window(araddr);
    assign wr_idx = aw.addr[SRAM_AW+1:2];
    assign rd_idx = araddr[SRAM_AW+1:2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
            for (int i = 0; i < SRAM_WORDS; i++) begin
                mem[i] <= 32'b0;
            end
        end else begin
            if (rd_take) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (wr_take) begin
                bvalid <= 1'b1;
                if (wr_hit) begin
                    for (int i = 0; i < 4; i++) begin
                        if (w.strb[i]) mem[wr_idx][i*8 +: 8] <= w.data[i*8 +: 8];
                    end
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Response payloads, held while valid is up.
    always_ff @(posedge clk) begin
        if (rd_take) begin
            r.data <= rd_hit ? mem[rd_idx] : 32'b0;
            r.resp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        end
        if (wr_take) begin
            b.resp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

// ==== lsu_ctrl.sv ====
`timescale 1ns/1ps

module lsu_ctrl
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        req_valid,
    input  lsu_req_t    req,
    output logic        req_ready,

    output logic        res_valid,
    output lsu_res_t    res,
    input  logic        res_ready,

    output logic        awvalid,
    output axi_aw_t     aw,
    input  logic        awready,
    output logic        wvalid,
    output axi_w_t      w,
    input  logic        wready,
    input  logic        bvalid,
    input  axi_b_t      b,
    output logic        bready,
    output logic        arvalid,
    output logic [31:0] araddr,
    input  logic        arready,
    input  logic        rvalid,
    input  axi_r_t      r,
    output logic        rready
);

    lsu_state_e  state;
    lsu_state_e  state_next;
    lsu_req_t    req_q;
    lsu_res_t    res_q;
    logic        aw_done;
    logic        w_done;
    logic        aw_hs;
    logic        w_hs;
    logic        wr_sent;
    logic [31:0] load_value;

    // ########################################
    // Channel drive, all from state.
    // ########################################

    assign req_ready = (state == IDLE);
    assign res_valid = (state == DONE);
    assign res       = res_q;
    assign arvalid   = (state == RD_ADDR);
    assign araddr    = req_q.addr;
    assign rready    = (state == RD_DATA);
    assign awvalid   = (state == WR_REQ) && !aw_done;
    assign wvalid    = (state == WR_REQ) && !w_done;
    assign aw.addr   = req_q.addr;
    assign bready    = (state == WR_RESP);

    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    assign wr_sent = (aw_done || aw_hs) && (w_done || w_hs); // Both write channels are through.

    lsu_store_align store_align_inst (
        .op       (req_q.op),
        .addr_off (req_q.addr[1:0]),
        .wdata    (req_q.wdata),
        .w        (w)
    );

    lsu_load_extend load_extend_inst (
        .op       (req_q.op),
        .addr_off (req_q.addr[1:0]),
        .word     (r.data),
        .value    (load_value)
    );

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    if (is_load(req.op)) begin
                        state_next = RD_ADDR;
                    end else if (is_store(req.op)) begin
                        state_next = WR_REQ;
                    end else begin
                        state_next = DONE;
                    end
                end
            end
            RD_ADDR: if (arready) state_next = RD_DATA;
            RD_DATA: if (rvalid) state_next = DONE;
            WR_REQ: if (wr_sent) state_next = WR_RESP;
            WR_RESP: if (bvalid) state_next = DONE;
            DONE: if (res_ready) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state <= state_next;
            if (state == WR_REQ && state_next != WR_REQ) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end else begin
                if (aw_hs) aw_done <= 1'b1;
                if (w_hs) w_done <= 1'b1;
            end
        end
    end

    // Request copy and result register.
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q       <= req;
            res_q.rd    <= req.rd;
            res_q.fault <= 1'b0;
            if (is_load(req.op) || is_store(req.op)) begin
                res_q.rdata <= 32'b0;
            end else begin
                res_q.rdata <= req.addr; // Pass-through returns its address.
            end
        end
        if (rvalid && rready) begin
            res_q.rdata <= load_value;
            res_q.fault <= (r.resp != RESP_OKAY);
        end
        if (bvalid && bready) begin
            res_q.fault <= (b.resp != RESP_OKAY);
        end
    end

endmodule

// ==== lsu_load_extend.sv ====
`timescale 1ns/1ps

module lsu_load_extend
    import lsu_pkg::*;
(
    input  mem_op_e     op,
    input  logic [1:0]  addr_off,
    input  logic [31:0] word,
    output logic [31:0] value
);

    logic [31:0] shifted;

    assign shifted = word >> {addr_off, 3'b000}; // Bring the addressed byte to bit 0.

    always_comb begin
        case (op)
            OP_LB: begin
                value = {{24{shifted[7]}}, shifted[7:0]};
            end
            OP_LH: begin
                value = {{16{shifted[15]}}, shifted[15:0]};
            end
            OP_LBU: begin
                value = {24'b0, shifted[7:0]};
            end
            OP_LHU: begin
                value = {16'b0, shifted[15:0]};
            end
            default: begin
                value = shifted; // LW keeps the whole word.
            end
        endcase
    end

endmodule

// ==== lsu_store_align.sv ====
`timescale 1ns/1ps

module lsu_store_align
    import lsu_pkg::*;
(
    input  mem_op_e     op,
    input  logic [1:0]  addr_off,
    input  logic [31:0] wdata,
    output axi_w_t      w
);

    logic [4:0] shamt;

    assign shamt = {addr_off, 3'b000}; // Byte offset in bits.

    always_comb begin
        w.data = wdata << shamt;
        case (op)
            OP_SB: begin
                w.strb = 4'b0001 << addr_off;
            end
            OP_SH: begin
                w.strb = 4'b0011 << addr_off;
            end
            OP_SW: begin
                w.strb = 4'b1111 << addr_off;
            end
            default: begin
                w.strb = 4'b0000; // Nothing is written for loads or pass-through.
            end
        endcase
    end

endmodule

// ==== lsu_pkg.sv ====
package lsu_pkg;

    // ########################################
    // Memory map and response codes
    // ########################################

    localparam logic [31:0] SRAM_BASE   = 32'h8000_0000;
    localparam int          SRAM_WORDS  = 256;
    localparam int          SRAM_AW     = 8;
    localparam logic [1:0]  RESP_OKAY   = 2'b00;
    localparam logic [1:0]  RESP_SLVERR = 2'b10;

    // ########################################
    // Operations and FSM states
    // ########################################

    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LB   = 4'd1,
        OP_LH   = 4'd2,
        OP_LW   = 4'd3,
        OP_LBU  = 4'd4,
        OP_LHU  = 4'd5,
        OP_SB   = 4'd6,
        OP_SH   = 4'd7,
        OP_SW   = 4'd8
    } mem_op_e;

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        RD_ADDR = 3'd1,
        RD_DATA = 3'd2,
        WR_REQ  = 3'd3,
        WR_RESP = 3'd4,
        DONE    = 3'd5
    } lsu_state_e;

    // ########################################
    // Bundles
    // ########################################

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [4:0]  rd;
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic [4:0]  rd;
        logic        fault;
    } lsu_res_t;

    typedef struct packed {
        logic [31:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    function automatic logic is_load(input mem_op_e op);
        return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    endfunction

    function automatic logic is_store(input mem_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

endpackage
